// ==== tb.f ====
+incdir+.
cp0Pkg.sv
cp0Timer.sv
cp0StatusCause.sv
cp0ExcRecord.sv
cp0ReadPort.sv
cp0Top.sv
tb_cp0.sv

// ==== Bender.yml ====
package:
  name: cp0

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cp0Pkg.sv
      - cp0Timer.sv
      - cp0StatusCause.sv
      - cp0ExcRecord.sv
      - cp0ReadPort.sv
      - cp0Top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cp0.sv

// ==== tb_cp0.sv ====
`include "cp0_consts.svh"

module tb_cp0;

    // Cycle budget of reset and the six tests
    localparam int budgetCycles = 16 + 10 + 52 + 140 + 60 + 70 + 20;

    logic              clk = 1'b0;
    logic              rst;
    cp0Pkg::cp0Write_t wr;
    cp0Pkg::excReq_t   exc;
    logic [5:0]        interrupt;
    logic [4:0]        rdAddr;
    logic [2:0]        rdSel;
    logic [31:0]       rdData;
    cp0Pkg::cp0Ctrl_t  ctrl;

    logic [31:0] lfsr = 32'h1f5a_3587;
    int          checks = 0;
    int          errors = 0;
    int          testErrors = 0;

    // Expected register state
    logic        mBev = 1'b1, mExl = 1'b0, mIe = 1'b0, mBd = 1'b0, mTi = 1'b0;
    logic [7:0]  mIm = 8'h0, mIp = 8'h0;
    logic [4:0]  mExcCode = 5'h0;
    logic [31:0] mCount = 32'h0, mCompare = 32'h0, mEpc = 32'h0, mBadVAddr = 32'h0;

    cp0Top cp0Top_inst (
        .clk, .rst, .wr, .exc, .interrupt, .rdAddr, .rdSel, .rdData, .ctrl
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // Taps 32, 22, 2, 1
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] refRead(input logic [4:0] addr, input logic [2:0] sel);
        case (addr)
            `CP0_REG_BADVADDR: return mBadVAddr;
            `CP0_REG_COUNT:    return mCount;
            `CP0_REG_COMPARE:  return mCompare;
            `CP0_REG_STATUS:   return {9'b0, mBev, 6'b0, mIm, 6'b0, mExl, mIe};
            `CP0_REG_CAUSE:    return {mBd, mTi, 14'b0, mIp, 1'b0, mExcCode, 2'b0};
            `CP0_REG_EPC:      return mEpc;
            `CP0_REG_PRID:     return (sel == 3'd0) ? `CP0_PRID_VALUE : 32'h0;
            default:           return 32'h0;
        endcase
    endfunction

    function automatic logic [4:0] codeFor(input cp0Pkg::excKind_e kind, input logic [4:0] old);
        case (kind)
            cp0Pkg::excInterrupt:                    return `CP0_EXC_INT;
            cp0Pkg::excAdelIf, cp0Pkg::excAdelMem:   return `CP0_EXC_ADEL;
            cp0Pkg::excAdesMem:                      return `CP0_EXC_ADES;
            cp0Pkg::excSyscall:                      return `CP0_EXC_SYS;
            cp0Pkg::excBreak:                        return `CP0_EXC_BP;
            cp0Pkg::excReservedInstr:                return `CP0_EXC_RI;
            cp0Pkg::excOverflow:                     return `CP0_EXC_OV;
            cp0Pkg::excTrap:                         return `CP0_EXC_TR;
            default:                                 return old;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic endTest(input string name);
        $display("%s: %s (%0d errors)", name, (testErrors == 0) ? "ok" : "failed", testErrors);
        testErrors = 0;
    endtask

    // All tasks below start and end on a falling edge
    task automatic readCheck(input string name, input logic [4:0] addr, input logic [2:0] sel);
        rdAddr = addr;
        rdSel  = sel;
        #1;
        check(name, rdData, refRead(addr, sel));
        @(negedge clk);
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        wr.en   = 1'b1;
        wr.addr = addr;
        wr.sel  = 3'd0;
        wr.data = data;
        @(negedge clk);
        wr.en = 1'b0;
    endtask

    task automatic raiseExc(input cp0Pkg::excKind_e kind, input logic [31:0] pc,
                            input logic ds, input logic [31:0] alu);
        logic taken;
        taken = (kind != cp0Pkg::excNone) && (kind != cp0Pkg::excRefetch);
        if (taken && !mExl && kind != cp0Pkg::excEret) begin
            mEpc = ds ? pc - `CP0_DELAY_SLOT_OFFSET : pc;
            mBd  = ds;
        end
        if (taken)
            mExl = (kind != cp0Pkg::excEret);
        if (kind == cp0Pkg::excAdelIf)
            mBadVAddr = pc;
        else if (kind == cp0Pkg::excAdelMem || kind == cp0Pkg::excAdesMem)
            mBadVAddr = alu;
        mExcCode = codeFor(kind, mExcCode);
        exc.kind        = kind;
        exc.pc          = pc;
        exc.inDelaySlot = ds;
        exc.aluOut      = alu;
        @(negedge clk);
        exc.kind = cp0Pkg::excNone;
    endtask

    task automatic softwareWrites();
        logic [31:0] d;
        for (int i = 0; i < 6; i++) begin
            d = randBits(32);
            writeReg(`CP0_REG_COMPARE, d);
            mCompare = d;
            mTi      = 1'b0;
            mIp[7:2] = 6'h0;   // Reset-time match has long passed
            readCheck("Compare", `CP0_REG_COMPARE, 3'd0);
            d = randBits(32);
            writeReg(`CP0_REG_STATUS, d);
            {mBev, mIm, mExl, mIe} = {d[22], d[15:8], d[1], d[0]};
            check("ctrl.ie", ctrl.ie, mIe);
            check("ctrl.im", ctrl.im, mIm);
            check("ctrl.bev", ctrl.bev, mBev);
            readCheck("Status", `CP0_REG_STATUS, 3'd0);
            d = randBits(32);
            writeReg(`CP0_REG_CAUSE, d);
            mIp[1:0] = d[9:8];
            readCheck("Cause", `CP0_REG_CAUSE, 3'd0);
            d = randBits(32);
            writeReg(`CP0_REG_EPC, d);
            mEpc = d;
            readCheck("EPC", `CP0_REG_EPC, 3'd0);
        end
    endtask

    task automatic timerInterrupt();
        logic [31:0] c0;
        logic [31:0] cause;
        logic        ipCtrl;
        int          k;
        int          waited;
        for (int i = 0; i < 2; i++) begin
            c0 = randBits(32);
            k  = 2 + randBits(3);
            writeReg(`CP0_REG_COUNT, c0);
            writeReg(`CP0_REG_COMPARE, c0 + k);
            cause  = 32'h0;
            ipCtrl = 1'b0;
            waited = 0;
            rdAddr = `CP0_REG_CAUSE;
            while (!cause[30] && waited < 2 * k + 6) begin
                #1;
                cause  = rdData;
                ipCtrl = ctrl.ip[7];
                waited++;
                @(negedge clk);
            end
            if (!cause[30]) begin
                errors++;
                testErrors++;
                $display("Cause.TI was not set within %0d cycles of the Compare match", waited);
            end else begin
                // Match after 2k edges, TI on the edge after that
                check("TI cycles", waited, 2 * k + 1);
                check("Cause.IP7", cause[15], 1'b1);
                check("ctrl.ip[7]", ipCtrl, 1'b1);
            end
            writeReg(`CP0_REG_COMPARE, c0);   // Count is past this value so no new match
            mCompare = c0;
            mTi      = 1'b0;
            readCheck("Cause", `CP0_REG_CAUSE, 3'd0);
        end
    endtask

    initial begin
        logic [31:0]      v;
        int               n;
        cp0Pkg::excKind_e kind;
        rst       = 1'b1;
        wr        = '0;
        exc       = '0;
        interrupt = 6'h0;
        rdAddr    = 5'd0;
        rdSel     = 3'd0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // Cause and Count before the reset-time timer match shows up
        readCheck("Cause", `CP0_REG_CAUSE, 3'd0);
        readCheck("Count", `CP0_REG_COUNT, 3'd0);
        readCheck("Status", `CP0_REG_STATUS, 3'd0);
        readCheck("EPC", `CP0_REG_EPC, 3'd0);
        readCheck("PRId", `CP0_REG_PRID, 3'd0);
        readCheck("PRId sel 1", `CP0_REG_PRID, 3'd1);
        endTest("Reset values");

        softwareWrites();
        endTest("Software writes");

        for (int i = 0; i < 4; i++) begin
            v = randBits(32);
            n = 1 + randBits(4);
            writeReg(`CP0_REG_COUNT, v);
            repeat (2 * n) @(negedge clk);
            mCount = v + n;
            readCheck("Count", `CP0_REG_COUNT, 3'd0);
        end
        endTest("Count rate");

        timerInterrupt();
        endTest("Timer interrupt");

        raiseExc(cp0Pkg::excEret, 32'h0, 1'b0, 32'h0);
        for (int i = 0; i < 12; i++) begin
            kind = cp0Pkg::excKind_e'(5'(randBits(4) % 12));
            if (i % 4 == 3)
                kind = cp0Pkg::excEret;
            raiseExc(kind, {30'(randBits(30)), 2'b00}, 1'(randBits(1)), randBits(32));
            check("ctrl.exl", ctrl.exl, mExl);
            check("ctrl.epc", ctrl.epc, mEpc);
            readCheck("EPC", `CP0_REG_EPC, 3'd0);
            readCheck("Cause", `CP0_REG_CAUSE, 3'd0);
            readCheck("BadVAddr", `CP0_REG_BADVADDR, 3'd0);
            readCheck("Status", `CP0_REG_STATUS, 3'd0);
        end
        // Nested entry keeps the first return address
        raiseExc(cp0Pkg::excSyscall, 32'h0000_1000, 1'b1, 32'h0);
        raiseExc(cp0Pkg::excOverflow, 32'h0000_2000, 1'b0, 32'h0);
        check("ctrl.exl", ctrl.exl, 1'b1);
        check("ctrl.epc", ctrl.epc, 32'h0000_0ffc);
        readCheck("Cause", `CP0_REG_CAUSE, 3'd0);
        raiseExc(cp0Pkg::excEret, 32'h0, 1'b0, 32'h0);
        check("ctrl.exl", ctrl.exl, 1'b0);
        readCheck("Status", `CP0_REG_STATUS, 3'd0);
        endTest("Exceptions");

        for (int i = 0; i < 8; i++) begin
            interrupt = 6'(randBits(6));
            @(negedge clk);
            mIp[7:2] = interrupt;
            check("ctrl.ip", ctrl.ip, mIp);
            readCheck("Cause", `CP0_REG_CAUSE, 3'd0);
        end
        interrupt = 6'h0;
        endTest("Hardware interrupts");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        #(budgetCycles * 8 + 400);
        $display("Timeout: the tests did not finish in %0d cycles", budgetCycles + 50);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== cp0Top.sv ====
module cp0Top (
    input  logic              clk,
    input  logic              rst,
    input  cp0Pkg::cp0Write_t wr,
    input  cp0Pkg::excReq_t   exc,
    input  logic [5:0]        interrupt,
    input  logic [4:0]        rdAddr,
    input  logic [2:0]        rdSel,
    output logic [31:0]       rdData,
    output cp0Pkg::cp0Ctrl_t  ctrl
);

    logic        timerIrq;
    logic        ti;
    logic [31:0] count;
    logic [31:0] compare;
    logic        bev;
    logic        ie;
    logic [7:0]  im;
    logic [7:0]  ip;
    logic        exl;
    logic        bd;
    logic [31:0] epc;
    logic [31:0] badVAddr;
    logic [4:0]  excCode;

    cp0Timer cp0Timer_inst (
        .clk, .rst, .wr, .count, .compare, .timerIrq, .ti
    );

    cp0StatusCause cp0StatusCause_inst (
        .clk, .rst, .wr, .interrupt, .timerIrq, .bev, .ie, .im, .ip
    );

    cp0ExcRecord cp0ExcRecord_inst (
        .clk, .rst, .wr, .exc, .exl, .bd, .epc, .badVAddr, .excCode
    );

    cp0ReadPort cp0ReadPort_inst (
        .rdAddr, .rdSel, .bev, .im, .exl, .ie, .bd, .ti, .ip, .excCode,
        .count, .compare, .epc, .badVAddr, .rdData
    );

    // To exception detection in the memory stage
    assign ctrl.bev = bev;
    assign ctrl.im  = im;
    assign ctrl.exl = exl;
    assign ctrl.ie  = ie;
    assign ctrl.ip  = ip;
    assign ctrl.epc = epc;

endmodule

// ==== cp0ReadPort.sv ====
`include "cp0_consts.svh"

module cp0ReadPort (
    input  logic [4:0]  rdAddr,
    input  logic [2:0]  rdSel,
    input  logic        bev,
    input  logic [7:0]  im,
    input  logic        exl,
    input  logic        ie,
    input  logic        bd,
    input  logic        ti,
    input  logic [7:0]  ip,
    input  logic [4:0]  excCode,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    input  logic [31:0] epc,
    input  logic [31:0] badVAddr,
    output logic [31:0] rdData
);

    cp0Pkg::cp0Word_u statusWord;
    cp0Pkg::cp0Word_u causeWord;

    always_comb begin
        statusWord            = '0;
        statusWord.status.bev = bev;
        statusWord.status.im  = im;
        statusWord.status.exl = exl;
        statusWord.status.ie  = ie;

        causeWord               = '0;
        causeWord.cause.bd      = bd;
        causeWord.cause.ti      = ti;
        causeWord.cause.ip7_2   = ip[7:2];
        causeWord.cause.ip1_0   = ip[1:0];
        causeWord.cause.excCode = excCode;
    end

    always_comb begin
        case (rdAddr)
            `CP0_REG_BADVADDR: rdData = badVAddr;
            `CP0_REG_COUNT:    rdData = count;
            `CP0_REG_COMPARE:  rdData = compare;
            `CP0_REG_STATUS:   rdData = statusWord.raw;
            `CP0_REG_CAUSE:    rdData = causeWord.raw;
            `CP0_REG_EPC:      rdData = epc;
            `CP0_REG_PRID:     rdData = (rdSel == 3'd0) ? `CP0_PRID_VALUE : 32'h0;
            default:           rdData = 32'h0;    // Unimplemented
        endcase
    end

endmodule

// ==== cp0ExcRecord.sv ====
`include "cp0_consts.svh"

module cp0ExcRecord (
    input  logic              clk,
    input  logic              rst,
    input  cp0Pkg::cp0Write_t wr,
    input  cp0Pkg::excReq_t   exc,
    output logic              exl,
    output logic              bd,
    output logic [31:0]       epc,
    output logic [31:0]       badVAddr,
    output logic [4:0]        excCode
);

    cp0Pkg::cp0Word_u wrWord;
    logic             statusWr;
    logic             epcWr;
    logic             taken;
    logic             isEret;
    logic             record;    // Captures EPC and BD on first-level entry

    assign wrWord   = wr.data;
    assign statusWr = wr.en && (wr.addr == `CP0_REG_STATUS);
    assign epcWr    = wr.en && (wr.addr == `CP0_REG_EPC);

    assign taken  = (exc.kind != cp0Pkg::excNone) && (exc.kind != cp0Pkg::excRefetch);
    assign isEret = (exc.kind == cp0Pkg::excEret);
    assign record = !exl && taken && !isEret;

    always_ff @(posedge clk) begin
        if (rst) begin
            exl <= 1'b0;
        end else if (taken) begin
            exl <= !isEret;
        end else if (statusWr) begin
            exl <= wrWord.status.exl;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= `CP0_EPC_RESET;
            bd  <= 1'b0;
        end else if (record) begin
            // Return to the branch instead of the slot
            epc <= exc.inDelaySlot ? exc.pc - `CP0_DELAY_SLOT_OFFSET : exc.pc;
            bd  <= exc.inDelaySlot;
        end else if (epcWr) begin
            epc <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badVAddr <= `CP0_BADVADDR_RESET;
        end else begin
            case (exc.kind)
                cp0Pkg::excAdelIf:  badVAddr <= exc.pc;
                cp0Pkg::excAdelMem,
                cp0Pkg::excAdesMem: badVAddr <= exc.aluOut;
                default:            badVAddr <= badVAddr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            excCode <= `CP0_EXC_INT;
        end else begin
            case (exc.kind)
                cp0Pkg::excInterrupt:     excCode <= `CP0_EXC_INT;
                cp0Pkg::excAdelIf,
                cp0Pkg::excAdelMem:       excCode <= `CP0_EXC_ADEL;
                cp0Pkg::excAdesMem:       excCode <= `CP0_EXC_ADES;
                cp0Pkg::excSyscall:       excCode <= `CP0_EXC_SYS;
                cp0Pkg::excBreak:         excCode <= `CP0_EXC_BP;
                cp0Pkg::excReservedInstr: excCode <= `CP0_EXC_RI;
                cp0Pkg::excOverflow:      excCode <= `CP0_EXC_OV;
                cp0Pkg::excTrap:          excCode <= `CP0_EXC_TR;
                default:                  excCode <= excCode;  // None, Refetch, Eret
            endcase
        end
    end

    // Nested exceptions must not lose the original return address
    epcHeldDuringExl: assert property (@(posedge clk) disable iff (rst)
        (exl && !epcWr) |=> $stable(epc));

endmodule

// ==== cp0StatusCause.sv ====
`include "cp0_consts.svh"

module cp0StatusCause (
    input  logic              clk,
    input  logic              rst,
    input  cp0Pkg::cp0Write_t wr,
    input  logic [5:0]        interrupt,
    input  logic              timerIrq,
    output logic              bev,
    output logic              ie,
    output logic [7:0]        im,
    output logic [7:0]        ip
);

    cp0Pkg::cp0Word_u wrWord;
    logic             statusWr;
    logic             causeWr;
    logic [5:0]       hwIrq;

    assign wrWord   = wr.data;
    assign statusWr = wr.en && (wr.addr == `CP0_REG_STATUS);
    assign causeWr  = wr.en && (wr.addr == `CP0_REG_CAUSE);

    // Timer shares the IP7 line
    assign hwIrq = interrupt | {timerIrq, 5'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            bev <= `CP0_BEV_RESET;
            im  <= 8'h00;
            ie  <= 1'b0;
        end else if (statusWr) begin
            bev <= wrWord.status.bev;
            im  <= wrWord.status.im;
            ie  <= wrWord.status.ie;
        end
    end

    // Hardware lines sampled every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ip[7:2] <= 6'b0;
        end else begin
            ip[7:2] <= hwIrq;
        end
    end

    // IP1_0 is the only writable part of Cause
    always_ff @(posedge clk) begin
        if (rst) begin
            ip[1:0] <= 2'b0;
        end else if (causeWr) begin
            ip[1:0] <= wrWord.cause.ip1_0;
        end
    end

endmodule

// ==== cp0Timer.sv ====
`include "cp0_consts.svh"

module cp0Timer (
    input  logic              clk,
    input  logic              rst,
    input  cp0Pkg::cp0Write_t wr,
    output logic [31:0]       count,
    output logic [31:0]       compare,
    output logic              timerIrq,
    output logic              ti
);

    logic half;       // Count advances when set
    logic countWr;
    logic compareWr;

    assign countWr   = wr.en && (wr.addr == `CP0_REG_COUNT);
    assign compareWr = wr.en && (wr.addr == `CP0_REG_COMPARE);
    assign timerIrq  = (count == compare);

    always_ff @(posedge clk) begin
        if (rst) begin
            half  <= 1'b0;
            count <= `CP0_COUNT_RESET;
        end else if (countWr) begin
            half  <= 1'b0;     // Restart the divider phase
            count <= wr.data;
        end else begin
            half <= ~half;
            if (half) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            compare <= `CP0_COMPARE_RESET;
        end else if (compareWr) begin
            compare <= wr.data;
        end
    end

    // Sticky until software rewrites Compare
    always_ff @(posedge clk) begin
        if (rst) begin
            ti <= 1'b0;
        end else if (compareWr) begin
            ti <= 1'b0;
        end else if (timerIrq) begin
            ti <= 1'b1;
        end
    end

    tiClearOnlyByCompare: assert property (@(posedge clk) disable iff (rst)
        $fell(ti) |-> $past(compareWr || rst));

endmodule

// ==== cp0Pkg.sv ====
package cp0Pkg;

    typedef enum logic [4:0] {
        excNone,
        excInterrupt,
        excAdelIf,        // Fetch address error
        excAdelMem,
        excAdesMem,
        excSyscall,
        excBreak,
        excReservedInstr,
        excOverflow,
        excTrap,
        excEret,
        excRefetch        // Pipeline flush rather than an exception
    } excKind_e;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [2:0]  sel;
        logic [31:0] data;
    } cp0Write_t;

    typedef struct packed {
        excKind_e    kind;
        logic [31:0] pc;
        logic        inDelaySlot;
        logic [31:0] aluOut;      // Faulting data address
    } excReq_t;

    typedef struct packed {
        logic [8:0]  zeroHi;
        logic        bev;
        logic [5:0]  zeroMid;
        logic [7:0]  im;
        logic [5:0]  zeroLo;
        logic        exl;
        logic        ie;
    } statusView_t;

    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [13:0] zeroHi;
        logic [5:0]  ip7_2;
        logic [1:0]  ip1_0;
        logic        zeroMid;
        logic [4:0]  excCode;
        logic [1:0]  zeroLo;
    } causeView_t;

    typedef union packed {
        logic [31:0] raw;
        statusView_t status;
        causeView_t  cause;
    } cp0Word_u;

    // Fields the exception detector looks at
    typedef struct packed {
        logic        bev;
        logic [7:0]  im;
        logic        exl;
        logic        ie;
        logic [7:0]  ip;      // IP7_2 then IP1_0
        logic [31:0] epc;
    } cp0Ctrl_t;

endpackage

// ==== cp0_consts.svh ====
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// Register numbers
`define CP0_REG_BADVADDR       5'd8
`define CP0_REG_COUNT          5'd9
`define CP0_REG_COMPARE        5'd11
`define CP0_REG_STATUS         5'd12
`define CP0_REG_CAUSE          5'd13
`define CP0_REG_EPC            5'd14
`define CP0_REG_PRID           5'd15

// Cause.ExcCode values
`define CP0_EXC_INT            5'h00
`define CP0_EXC_ADEL           5'h04
`define CP0_EXC_ADES           5'h05
`define CP0_EXC_SYS            5'h08
`define CP0_EXC_BP             5'h09
`define CP0_EXC_RI             5'h0a
`define CP0_EXC_OV             5'h0c
`define CP0_EXC_TR             5'h0d

`define CP0_PRID_VALUE         32'h0000_4220
`define CP0_DELAY_SLOT_OFFSET  32'd4

`define CP0_BEV_RESET          1'b1
`define CP0_COUNT_RESET        32'h0
`define CP0_COMPARE_RESET      32'h0
`define CP0_EPC_RESET          32'h0
`define CP0_BADVADDR_RESET     32'h0

`endif
